/* logic/dif_params.svh */
`ifndef DIF_PARAMS_SVH
`define DIF_PARAMS_SVH

// Stream word and threshold DAC widths
`define DIF_DATA_WIDTH 16
`define DIF_DAC_WIDTH 10

// Charge-injection channel word, one bit per channel
`define DIF_CTEST_WIDTH 64

// Wishbone word address width, data bus is 32 bits
`define DIF_WB_ADDR_WIDTH 4

////////////////////
// Register map
////////////////////
`define DIF_REG_MODE 4'd0
`define DIF_REG_VTH01 4'd1
`define DIF_REG_VTH2 4'd2
`define DIF_REG_CTEST_LO 4'd3
`define DIF_REG_CTEST_HI 4'd4
`define DIF_REG_CONTROL 4'd5
`define DIF_REG_SCURVE_RANGE 4'd6
`define DIF_REG_SCURVE_WINDOW 4'd7
`define DIF_REG_STATUS 4'd8

// Tag in the top bits of an S-curve header word
`define DIF_MARKER_WIDTH 6
`define DIF_SCURVE_MARKER 6'b101010

`endif

/* logic/difModePkg.sv */
`default_nettype none

package difModePkg;

  // Readout source selected by the host
  // Values outside the list route like acquisition
  typedef enum logic [3:0] {
    ACQUISITION_MODE = 4'd0,
    SCURVE_TEST_MODE = 4'd1,
    ADC_CONTROL_MODE = 4'd2
  } readoutMode_e;

endpackage

`default_nettype wire

/* logic/scurvePkg.sv */
`default_nettype none

`include "dif_params.svh"

package scurvePkg;

  // One step of the sweep runs LOAD through SEND_COUNT
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    WAIT_DONE,
    COUNT,
    SEND_HEADER,
    SEND_COUNT,
    NEXT_STEP
  } sequencerState_e;

  typedef struct packed {
    logic [`DIF_MARKER_WIDTH-1:0] marker;
    logic [`DIF_DAC_WIDTH-1:0] dac;
  } scurveHeader_t;

  // Header word and count word share one stream word
  typedef union packed {
    scurveHeader_t header;
    logic [`DIF_DATA_WIDTH-1:0] count;
  } scurveWord_u;

endpackage

`default_nettype wire

/* logic/commandRegisters.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dif_params.svh"

module commandRegisters
  import difModePkg::*;
(
  input  logic Clk,
  input  logic reset,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [`DIF_WB_ADDR_WIDTH-1:0] wbAdr,
  input  logic [31:0] wbDatWrite,
  output logic [31:0] wbDatRead,
  output logic wbAck,
  input  logic sequencerBusy,
  input  logic MicrorocConfigurationDone,
  output readoutMode_e ModeSelect,
  output logic [`DIF_DAC_WIDTH-1:0] CommandVth0Dac,
  output logic [`DIF_DAC_WIDTH-1:0] CommandVth1Dac,
  output logic [`DIF_DAC_WIDTH-1:0] CommandVth2Dac,
  output logic [`DIF_CTEST_WIDTH-1:0] CommandCTestChannel,
  output logic commandParameterLoad,
  output logic scurveStart,
  output logic CommandAcquisitionStartStop,
  output logic CommandAdcStartStop,
  output logic [`DIF_DAC_WIDTH-1:0] scurveStartDac,
  output logic [`DIF_DAC_WIDTH-1:0] scurveEndDac,
  output logic [15:0] windowLength
);

  logic wbAccess;
  logic wbWrite;

  // New access only while no ack is out
  assign wbAccess = wbCyc && wbStb && !wbAck;
  assign wbWrite = wbAccess && wbWe;

  ////////////////////
  // Register writes
  ////////////////////
  always_ff @(posedge Clk) begin
    if (reset) begin
      wbAck <= 1'b0;
      ModeSelect <= ACQUISITION_MODE;
      CommandVth0Dac <= '0;
      CommandVth1Dac <= '0;
      CommandVth2Dac <= '0;
      CommandCTestChannel <= '0;
      commandParameterLoad <= 1'b0;
      scurveStart <= 1'b0;
      CommandAcquisitionStartStop <= 1'b0;
      CommandAdcStartStop <= 1'b0;
      scurveStartDac <= '0;
      scurveEndDac <= '0;
      windowLength <= '0;
    end else begin
      wbAck <= wbAccess;
      commandParameterLoad <= 1'b0;
      scurveStart <= 1'b0;
      if (wbWrite) begin
        case (wbAdr)
          `DIF_REG_MODE: ModeSelect <= readoutMode_e'(wbDatWrite[3:0]);
          `DIF_REG_VTH01: begin
            CommandVth0Dac <= wbDatWrite[9:0];
            CommandVth1Dac <= wbDatWrite[25:16];
          end
          `DIF_REG_VTH2: CommandVth2Dac <= wbDatWrite[9:0];
          `DIF_REG_CTEST_LO: CommandCTestChannel[31:0] <= wbDatWrite;
          `DIF_REG_CTEST_HI: CommandCTestChannel[63:32] <= wbDatWrite;
          `DIF_REG_CONTROL: begin
            // Bits 0 and 1 strobe, bits 2 and 3 hold
            commandParameterLoad <= wbDatWrite[0];
            scurveStart <= wbDatWrite[1];
            CommandAcquisitionStartStop <= wbDatWrite[2];
            CommandAdcStartStop <= wbDatWrite[3];
          end
          `DIF_REG_SCURVE_RANGE: begin
            scurveStartDac <= wbDatWrite[9:0];
            scurveEndDac <= wbDatWrite[25:16];
          end
          `DIF_REG_SCURVE_WINDOW: windowLength <= wbDatWrite[15:0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////
  // Readback
  ////////////////////
  always_comb begin
    case (wbAdr)
      `DIF_REG_MODE: wbDatRead = {28'd0, ModeSelect};
      `DIF_REG_VTH01: wbDatRead = {6'd0, CommandVth1Dac, 6'd0, CommandVth0Dac};
      `DIF_REG_VTH2: wbDatRead = {22'd0, CommandVth2Dac};
      `DIF_REG_CTEST_LO: wbDatRead = CommandCTestChannel[31:0];
      `DIF_REG_CTEST_HI: wbDatRead = CommandCTestChannel[63:32];
      // Strobe bits always read as zero
      `DIF_REG_CONTROL: wbDatRead = {28'd0, CommandAdcStartStop,
                                     CommandAcquisitionStartStop, 2'b00};
      `DIF_REG_SCURVE_RANGE: wbDatRead = {6'd0, scurveEndDac, 6'd0, scurveStartDac};
      `DIF_REG_SCURVE_WINDOW: wbDatRead = {16'd0, windowLength};
      `DIF_REG_STATUS: wbDatRead = {30'd0, MicrorocConfigurationDone, sequencerBusy};
      default: wbDatRead = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/triggerWindowCounter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dif_params.svh"

module triggerWindowCounter (
  input  logic Clk,
  input  logic reset,
  input  logic Trigger,
  input  logic countStart,
  input  logic [15:0] windowLength,
  output logic countDone,
  output logic [`DIF_DATA_WIDTH-1:0] triggerCount
);

  logic [15:0] windowTimer;
  logic windowActive;
  logic triggerLast;

  always_ff @(posedge Clk) begin
    if (reset) begin
      windowTimer <= '0;
      windowActive <= 1'b0;
      triggerLast <= 1'b0;
      countDone <= 1'b0;
      triggerCount <= '0;
    end else begin
      triggerLast <= Trigger;
      countDone <= 1'b0;
      if (countStart) begin
        windowTimer <= windowLength;
        windowActive <= 1'b1;
        triggerCount <= '0;
      end else if (windowActive) begin
        // Rising edges only, saturating
        if (Trigger && !triggerLast && triggerCount != '1) begin
          triggerCount <= triggerCount + 1'b1;
        end
        windowTimer <= windowTimer - 1'b1;
        // Last cycle of the window, count is then held
        if (windowTimer <= 16'd1) begin
          windowActive <= 1'b0;
          countDone <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/scurveSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dif_params.svh"

module scurveSequencer
  import scurvePkg::*;
(
  input  logic Clk,
  input  logic reset,
  input  logic scurveStart,
  input  logic [`DIF_DAC_WIDTH-1:0] scurveStartDac,
  input  logic [`DIF_DAC_WIDTH-1:0] scurveEndDac,
  input  logic ConfigurationDone,
  input  logic countDone,
  input  logic [`DIF_DATA_WIDTH-1:0] triggerCount,
  input  logic FifoFull,
  output logic sequencerBusy,
  output logic ParameterLoad,
  output logic [`DIF_DAC_WIDTH-1:0] Vth0Dac,
  output logic countStart,
  output logic [`DIF_DATA_WIDTH-1:0] ScurveData,
  output logic ScurveDataEnable,
  output logic ForceExternalRaz
);

  sequencerState_e state;
  logic [`DIF_DAC_WIDTH-1:0] currentDac;
  logic enterCount;
  scurveWord_u outWord;

  ////////////////////
  // Step FSM
  ////////////////////
  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= IDLE;
      currentDac <= '0;
      enterCount <= 1'b0;
    end else begin
      enterCount <= 1'b0;
      case (state)
        IDLE: begin
          if (scurveStart) begin
            currentDac <= scurveStartDac;
            state <= LOAD;
          end
        end
        LOAD: state <= WAIT_DONE;
        WAIT_DONE: begin
          // Chip has taken the new Vth0
          if (ConfigurationDone) begin
            enterCount <= 1'b1;
            state <= COUNT;
          end
        end
        COUNT: begin
          if (countDone) begin
            state <= SEND_HEADER;
          end
        end
        SEND_HEADER: begin
          if (!FifoFull) begin
            state <= SEND_COUNT;
          end
        end
        SEND_COUNT: begin
          if (!FifoFull) begin
            state <= NEXT_STEP;
          end
        end
        NEXT_STEP: begin
          // End value is inclusive
          if (currentDac >= scurveEndDac) begin
            state <= IDLE;
          end else begin
            currentDac <= currentDac + 1'b1;
            state <= LOAD;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Output word, header first and then the count
  always_ff @(posedge Clk) begin
    if (state == COUNT && countDone) begin
      outWord.header.marker <= `DIF_SCURVE_MARKER;
      outWord.header.dac <= currentDac;
    end else if (state == SEND_HEADER && !FifoFull) begin
      outWord.count <= triggerCount;
    end
  end

  assign sequencerBusy = (state != IDLE);
  assign ParameterLoad = (state == LOAD);
  assign Vth0Dac = currentDac;
  // Window start and RAZ share the first COUNT cycle
  assign countStart = enterCount;
  assign ForceExternalRaz = enterCount;
  assign ScurveData = outWord;
  assign ScurveDataEnable = (state == SEND_HEADER) || (state == SEND_COUNT);

endmodule

`default_nettype wire

/* logic/acquisitionSwitcher.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dif_params.svh"

module acquisitionSwitcher
  import difModePkg::*;
(
  input  readoutMode_e ModeSelect,
  input  logic [`DIF_DATA_WIDTH-1:0] MicrorocAcquisitionData,
  input  logic [`DIF_DATA_WIDTH-1:0] ScurveData,
  input  logic [`DIF_DATA_WIDTH-1:0] AdcData,
  output logic [`DIF_DATA_WIDTH-1:0] OutTestData,
  input  logic MicrorocAcquisitionDataEnable,
  input  logic ScurveDataEnable,
  input  logic AdcDataEnable,
  output logic OutTestDataEnable,
  input  logic ExternalFifoFull,
  output logic ExternalFifoFullToMicrorocAcquisition,
  output logic ExternalFifoFullToScurve,
  output logic ExternalFifoFullToAdc,
  input  logic CommandParameterLoad,
  input  logic ScurveParameterLoad,
  output logic OutMicrorocConfigurationParameterLoad,
  input  logic MicrorocConfigurationDone,
  output logic MicrorocConfigurationDoneToAcquisition,
  output logic ConfigurationDoneToScurve,
  input  logic [`DIF_CTEST_WIDTH-1:0] CommandCTestChannel,
  output logic [`DIF_CTEST_WIDTH-1:0] OutMicrorocCTestChannel,
  input  logic [`DIF_DAC_WIDTH-1:0] CommandVth0Dac,
  input  logic [`DIF_DAC_WIDTH-1:0] CommandVth1Dac,
  input  logic [`DIF_DAC_WIDTH-1:0] CommandVth2Dac,
  input  logic [`DIF_DAC_WIDTH-1:0] ScurveVth0Dac,
  output logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth0Dac,
  output logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth1Dac,
  output logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth2Dac,
  input  logic ScurveForceExternalRaz,
  output logic OutForceExternalRaz,
  input  logic CommandAcquisitionStartStop,
  input  logic ScurveStartStop,
  input  logic CommandAdcStartStop,
  output logic OutUsbStartStop
);

  always_comb begin
    // Acquisition routing, also used for undefined modes
    OutTestData = MicrorocAcquisitionData;
    OutTestDataEnable = MicrorocAcquisitionDataEnable;
    ExternalFifoFullToMicrorocAcquisition = ExternalFifoFull;
    ExternalFifoFullToScurve = 1'b0;
    ExternalFifoFullToAdc = 1'b0;
    OutMicrorocConfigurationParameterLoad = CommandParameterLoad;
    MicrorocConfigurationDoneToAcquisition = MicrorocConfigurationDone;
    ConfigurationDoneToScurve = 1'b0;
    OutMicrorocCTestChannel = CommandCTestChannel;
    OutMicrorocVth0Dac = CommandVth0Dac;
    OutMicrorocVth1Dac = CommandVth1Dac;
    OutMicrorocVth2Dac = CommandVth2Dac;
    OutForceExternalRaz = 1'b0;
    OutUsbStartStop = CommandAcquisitionStartStop;
    case (ModeSelect)
      SCURVE_TEST_MODE: begin
        // Sequencer owns stream, config load, Vth0 and RAZ
        OutTestData = ScurveData;
        OutTestDataEnable = ScurveDataEnable;
        ExternalFifoFullToMicrorocAcquisition = 1'b0;
        ExternalFifoFullToScurve = ExternalFifoFull;
        OutMicrorocConfigurationParameterLoad = ScurveParameterLoad;
        MicrorocConfigurationDoneToAcquisition = 1'b0;
        ConfigurationDoneToScurve = MicrorocConfigurationDone;
        OutMicrorocVth0Dac = ScurveVth0Dac;
        OutForceExternalRaz = ScurveForceExternalRaz;
        OutUsbStartStop = ScurveStartStop;
      end
      ADC_CONTROL_MODE: begin
        OutTestData = AdcData;
        OutTestDataEnable = AdcDataEnable;
        ExternalFifoFullToMicrorocAcquisition = 1'b0;
        ExternalFifoFullToAdc = ExternalFifoFull;
        OutUsbStartStop = CommandAdcStartStop;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/difControlTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dif_params.svh"

module difControlTop
  import difModePkg::*;
(
  input  logic Clk,
  input  logic reset,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [`DIF_WB_ADDR_WIDTH-1:0] wbAdr,
  input  logic [31:0] wbDatWrite,
  output logic [31:0] wbDatRead,
  output logic wbAck,
  input  logic [`DIF_DATA_WIDTH-1:0] MicrorocAcquisitionData,
  input  logic MicrorocAcquisitionDataEnable,
  input  logic [`DIF_DATA_WIDTH-1:0] AdcData,
  input  logic AdcDataEnable,
  input  logic ExternalFifoFull,
  output logic [`DIF_DATA_WIDTH-1:0] OutTestData,
  output logic OutTestDataEnable,
  output logic ExternalFifoFullToMicrorocAcquisition,
  output logic ExternalFifoFullToAdc,
  input  logic Trigger,
  input  logic MicrorocConfigurationDone,
  output logic MicrorocConfigurationDoneToAcquisition,
  output logic OutMicrorocConfigurationParameterLoad,
  output logic [`DIF_CTEST_WIDTH-1:0] OutMicrorocCTestChannel,
  output logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth0Dac,
  output logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth1Dac,
  output logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth2Dac,
  output logic OutForceExternalRaz,
  output logic OutUsbStartStop
);

  readoutMode_e modeSelect;
  logic [`DIF_DAC_WIDTH-1:0] commandVth0Dac;
  logic [`DIF_DAC_WIDTH-1:0] commandVth1Dac;
  logic [`DIF_DAC_WIDTH-1:0] commandVth2Dac;
  logic [`DIF_CTEST_WIDTH-1:0] commandCTestChannel;
  logic commandParameterLoad;
  logic scurveStart;
  logic commandAcquisitionStartStop;
  logic commandAdcStartStop;
  logic [`DIF_DAC_WIDTH-1:0] scurveStartDac;
  logic [`DIF_DAC_WIDTH-1:0] scurveEndDac;
  logic [15:0] windowLength;

  logic sequencerBusy;
  logic scurveParameterLoad;
  logic [`DIF_DAC_WIDTH-1:0] scurveVth0Dac;
  logic countStart;
  logic countDone;
  logic [`DIF_DATA_WIDTH-1:0] triggerCount;
  logic [`DIF_DATA_WIDTH-1:0] scurveData;
  logic scurveDataEnable;
  logic scurveForceExternalRaz;
  logic fifoFullToScurve;
  logic configurationDoneToScurve;

  commandRegisters i_commandRegisters (
    .Clk(Clk),
    .reset(reset),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatWrite(wbDatWrite),
    .wbDatRead(wbDatRead),
    .wbAck(wbAck),
    .sequencerBusy(sequencerBusy),
    .MicrorocConfigurationDone(MicrorocConfigurationDone),
    .ModeSelect(modeSelect),
    .CommandVth0Dac(commandVth0Dac),
    .CommandVth1Dac(commandVth1Dac),
    .CommandVth2Dac(commandVth2Dac),
    .CommandCTestChannel(commandCTestChannel),
    .commandParameterLoad(commandParameterLoad),
    .scurveStart(scurveStart),
    .CommandAcquisitionStartStop(commandAcquisitionStartStop),
    .CommandAdcStartStop(commandAdcStartStop),
    .scurveStartDac(scurveStartDac),
    .scurveEndDac(scurveEndDac),
    .windowLength(windowLength)
  );

  scurveSequencer i_scurveSequencer (
    .Clk(Clk),
    .reset(reset),
    .scurveStart(scurveStart),
    .scurveStartDac(scurveStartDac),
    .scurveEndDac(scurveEndDac),
    .ConfigurationDone(configurationDoneToScurve),
    .countDone(countDone),
    .triggerCount(triggerCount),
    .FifoFull(fifoFullToScurve),
    .sequencerBusy(sequencerBusy),
    .ParameterLoad(scurveParameterLoad),
    .Vth0Dac(scurveVth0Dac),
    .countStart(countStart),
    .ScurveData(scurveData),
    .ScurveDataEnable(scurveDataEnable),
    .ForceExternalRaz(scurveForceExternalRaz)
  );

  triggerWindowCounter i_triggerWindowCounter (
    .Clk(Clk),
    .reset(reset),
    .Trigger(Trigger),
    .countStart(countStart),
    .windowLength(windowLength),
    .countDone(countDone),
    .triggerCount(triggerCount)
  );

  acquisitionSwitcher i_acquisitionSwitcher (
    .ModeSelect(modeSelect),
    .MicrorocAcquisitionData(MicrorocAcquisitionData),
    .ScurveData(scurveData),
    .AdcData(AdcData),
    .OutTestData(OutTestData),
    .MicrorocAcquisitionDataEnable(MicrorocAcquisitionDataEnable),
    .ScurveDataEnable(scurveDataEnable),
    .AdcDataEnable(AdcDataEnable),
    .OutTestDataEnable(OutTestDataEnable),
    .ExternalFifoFull(ExternalFifoFull),
    .ExternalFifoFullToMicrorocAcquisition(ExternalFifoFullToMicrorocAcquisition),
    .ExternalFifoFullToScurve(fifoFullToScurve),
    .ExternalFifoFullToAdc(ExternalFifoFullToAdc),
    .CommandParameterLoad(commandParameterLoad),
    .ScurveParameterLoad(scurveParameterLoad),
    .OutMicrorocConfigurationParameterLoad(OutMicrorocConfigurationParameterLoad),
    .MicrorocConfigurationDone(MicrorocConfigurationDone),
    .MicrorocConfigurationDoneToAcquisition(MicrorocConfigurationDoneToAcquisition),
    .ConfigurationDoneToScurve(configurationDoneToScurve),
    .CommandCTestChannel(commandCTestChannel),
    .OutMicrorocCTestChannel(OutMicrorocCTestChannel),
    .CommandVth0Dac(commandVth0Dac),
    .CommandVth1Dac(commandVth1Dac),
    .CommandVth2Dac(commandVth2Dac),
    .ScurveVth0Dac(scurveVth0Dac),
    .OutMicrorocVth0Dac(OutMicrorocVth0Dac),
    .OutMicrorocVth1Dac(OutMicrorocVth1Dac),
    .OutMicrorocVth2Dac(OutMicrorocVth2Dac),
    .ScurveForceExternalRaz(scurveForceExternalRaz),
    .OutForceExternalRaz(OutForceExternalRaz),
    .CommandAcquisitionStartStop(commandAcquisitionStartStop),
    .ScurveStartStop(sequencerBusy),
    .CommandAdcStartStop(commandAdcStartStop),
    .OutUsbStartStop(OutUsbStartStop)
  );

endmodule

`default_nettype wire

/* bench/difControlTb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module difControlTb_assertions
  import difModePkg::*;
(
  input logic Clk,
  input logic reset,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input logic parameterLoad,
  input readoutMode_e modeSelect,
  input logic dataEnable,
  input logic fifoFull
);

  ////////////////////
  // Wishbone handshake
  ////////////////////
  ackInsideCycle: assert property (@(posedge Clk) disable iff (reset)
    wbAck |-> (wbCyc && wbStb))
    else $error("wbAck high outside an active Wishbone cycle");

  ackSingleCycle: assert property (@(posedge Clk) disable iff (reset)
    wbAck |=> !wbAck)
    else $error("wbAck high for two cycles in a row");

  ////////////////////
  // Pulses and stream
  ////////////////////
  loadSingleCycle: assert property (@(posedge Clk) disable iff (reset)
    parameterLoad |=> !parameterLoad)
    else $error("configuration load longer than one cycle");

  // A held S-curve word stays until the FIFO takes it
  enableHeldWhileFull: assert property (@(posedge Clk) disable iff (reset)
    (modeSelect == SCURVE_TEST_MODE && dataEnable && fifoFull) |=> dataEnable)
    else $error("S-curve stream enable dropped before the word moved");

endmodule

bind difControlTop difControlTb_assertions i_assertions (
  .Clk(Clk),
  .reset(reset),
  .wbCyc(wbCyc),
  .wbStb(wbStb),
  .wbAck(wbAck),
  .parameterLoad(OutMicrorocConfigurationParameterLoad),
  .modeSelect(modeSelect),
  .dataEnable(OutTestDataEnable),
  .fifoFull(ExternalFifoFull)
);

`default_nettype wire

/* bench/difControlTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dif_params.svh"

module difControlTb
  import scurvePkg::*;
();

  localparam logic [15:0] acqWord = 16'hA5C3;
  localparam logic [15:0] adcWord = 16'h3C5A;
  localparam logic [31:0] vth01Word = 32'h0155_00AA;
  localparam logic [31:0] vth2Word = 32'h0000_02F0;
  localparam logic [31:0] cTestLowWord = 32'h89AB_CDEF;
  localparam logic [31:0] cTestHighWord = 32'h0123_4567;
  localparam logic [9:0] sweepStartDac = 10'd100;
  localparam logic [9:0] sweepEndDac = 10'd102;
  localparam logic [15:0] windowCycles = 16'd8;

  logic Clk = 1'b0;
  logic reset;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [`DIF_WB_ADDR_WIDTH-1:0] wbAdr;
  logic [31:0] wbDatWrite;
  logic [31:0] wbDatRead;
  logic wbAck;
  logic [`DIF_DATA_WIDTH-1:0] MicrorocAcquisitionData;
  logic MicrorocAcquisitionDataEnable;
  logic [`DIF_DATA_WIDTH-1:0] AdcData;
  logic AdcDataEnable;
  logic ExternalFifoFull = 1'b0;
  logic [`DIF_DATA_WIDTH-1:0] OutTestData;
  logic OutTestDataEnable;
  logic ExternalFifoFullToMicrorocAcquisition;
  logic ExternalFifoFullToAdc;
  logic Trigger = 1'b0;
  logic MicrorocConfigurationDone = 1'b0;
  logic MicrorocConfigurationDoneToAcquisition;
  logic OutMicrorocConfigurationParameterLoad;
  logic [`DIF_CTEST_WIDTH-1:0] OutMicrorocCTestChannel;
  logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth0Dac;
  logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth1Dac;
  logic [`DIF_DAC_WIDTH-1:0] OutMicrorocVth2Dac;
  logic OutForceExternalRaz;
  logic OutUsbStartStop;

  integer seed = 19584;
  integer doneCountdown = 0;
  integer loadPulseCount = 0;
  integer razPulseCount = 0;
  integer doneToAcquisitionCycles = 0;
  integer failCount = 0;
  integer testStartFails = 0;
  integer testsRun = 0;
  integer testsFailed = 0;
  logic [31:0] randomWord;
  logic triggerToggle = 1'b0;
  logic fifoRandom = 1'b0;
  logic fifoFullLevel = 1'b0;
  logic captureOn = 1'b0;
  logic [`DIF_DATA_WIDTH-1:0] streamWords [$];
  logic [`DIF_DAC_WIDTH-1:0] loadDacs [$];
  string currentTest;

  difControlTop i_dut (.*);

  always #20 Clk = ~Clk;

  ////////////////////
  // Stimulus sources
  ////////////////////
  always @(posedge Clk) begin
    Trigger <= triggerToggle ? ~Trigger : 1'b0;
    if (fifoRandom) begin
      randomWord = $random(seed);
      ExternalFifoFull <= randomWord[0];
    end else begin
      ExternalFifoFull <= fifoFullLevel;
    end
    // Chip model, Done comes 3 to 10 cycles after each load
    if (reset) begin
      MicrorocConfigurationDone <= 1'b0;
      doneCountdown <= 0;
    end else if (OutMicrorocConfigurationParameterLoad) begin
      MicrorocConfigurationDone <= 1'b0;
      doneCountdown <= 3 + ({$random(seed)} % 8);
    end else if (doneCountdown > 0) begin
      doneCountdown <= doneCountdown - 1;
      if (doneCountdown == 1) begin
        MicrorocConfigurationDone <= 1'b1;
      end
    end
  end

  // Load pulses, RAZ pulses and accepted stream words
  always @(posedge Clk) begin
    if (OutMicrorocConfigurationParameterLoad) begin
      loadPulseCount <= loadPulseCount + 1;
    end
    if (captureOn && OutMicrorocConfigurationParameterLoad) begin
      loadDacs.push_back(OutMicrorocVth0Dac);
    end
    if (captureOn && OutForceExternalRaz) begin
      razPulseCount <= razPulseCount + 1;
    end
    if (captureOn && MicrorocConfigurationDoneToAcquisition) begin
      doneToAcquisitionCycles <= doneToAcquisitionCycles + 1;
    end
    if (captureOn && OutTestDataEnable && !ExternalFifoFull) begin
      streamWords.push_back(OutTestData);
    end
  end

  ////////////////////
  // Helpers
  ////////////////////
  task automatic checkValue(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("mismatch in test %s: %s expected 0x%0h, actual 0x%0h",
               currentTest, what, expected, actual);
      failCount++;
    end
  endtask

  task automatic startTest(input string name);
    currentTest = name;
    testStartFails = failCount;
  endtask

  task automatic finishTest();
    testsRun++;
    if (failCount > testStartFails) begin
      testsFailed++;
      $display("test %s: failed with %0d errors", currentTest, failCount - testStartFails);
    end else begin
      $display("test %s: passed", currentTest);
    end
  endtask

  task automatic writeRegister(input logic [3:0] address, input logic [31:0] data);
    bit gotAck;
    integer cycles;
    gotAck = 1'b0;
    @(posedge Clk);
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe <= 1'b1;
    wbAdr <= address;
    wbDatWrite <= data;
    for (cycles = 0; cycles < 16 && !gotAck; cycles++) begin
      @(posedge Clk);
      gotAck = wbAck;
    end
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe <= 1'b0;
    assert (gotAck) else begin
      $display("timeout in test %s: no Wishbone ack for the write to register %0d",
               currentTest, address);
      failCount++;
    end
  endtask

  task automatic readRegister(input logic [3:0] address, output logic [31:0] data);
    bit gotAck;
    integer cycles;
    gotAck = 1'b0;
    data = 32'd0;
    @(posedge Clk);
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe <= 1'b0;
    wbAdr <= address;
    for (cycles = 0; cycles < 16 && !gotAck; cycles++) begin
      @(posedge Clk);
      gotAck = wbAck;
      // Read data is valid while ack is high
      if (gotAck) begin
        data = wbDatRead;
      end
    end
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    assert (gotAck) else begin
      $display("timeout in test %s: no Wishbone ack for the read of register %0d",
               currentTest, address);
      failCount++;
    end
  endtask

  // Acquisition routing, shared by mode 0 and undefined modes
  task automatic checkAcquisitionBehavior();
    integer pulsesBefore;
    integer cycles;
    checkValue("stream data", acqWord, OutTestData);
    checkValue("stream enable", 1, OutTestDataEnable);
    checkValue("full to acquisition", 1, ExternalFifoFullToMicrorocAcquisition);
    checkValue("full to ADC", 0, ExternalFifoFullToAdc);
    checkValue("Vth0", vth01Word[9:0], OutMicrorocVth0Dac);
    checkValue("Vth1", vth01Word[25:16], OutMicrorocVth1Dac);
    checkValue("Vth2", vth2Word[9:0], OutMicrorocVth2Dac);
    checkValue("channel word", {cTestHighWord, cTestLowWord}, OutMicrorocCTestChannel);
    checkValue("start/stop", 1, OutUsbStartStop);
    checkValue("RAZ", 0, OutForceExternalRaz);
    pulsesBefore = loadPulseCount;
    writeRegister(`DIF_REG_CONTROL, 32'h5);
    repeat (4) @(posedge Clk);
    checkValue("load pulses", 1, loadPulseCount - pulsesBefore);
    // Chip answers the load, Done goes back to acquisition
    for (cycles = 0; cycles < 16 && !MicrorocConfigurationDone; cycles++) begin
      @(posedge Clk);
    end
    assert (MicrorocConfigurationDone) else begin
      $display("timeout in test %s: no configuration done after the load pulse",
               currentTest);
      failCount++;
    end
    checkValue("done to acquisition", 1, MicrorocConfigurationDoneToAcquisition);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic testRegisters();
    logic [3:0] addresses [8];
    logic [31:0] values [8];
    logic [31:0] readData;
    integer i;
    startTest("registers");
    addresses = '{`DIF_REG_MODE, `DIF_REG_VTH01, `DIF_REG_VTH2, `DIF_REG_CTEST_LO,
                  `DIF_REG_CTEST_HI, `DIF_REG_CONTROL, `DIF_REG_SCURVE_RANGE,
                  `DIF_REG_SCURVE_WINDOW};
    // Control holds only the two run levels
    values = '{32'h2, 32'h02A5_015A, 32'h0000_033C, 32'hDEAD_BEEF,
               32'h0F1E_2D3C, 32'hC, 32'h0123_0045, 32'h0000_BEEF};
    for (i = 0; i < 8; i++) begin
      writeRegister(addresses[i], values[i]);
    end
    for (i = 0; i < 8; i++) begin
      readRegister(addresses[i], readData);
      checkValue($sformatf("readback of register %0d", addresses[i]), values[i], readData);
    end
    writeRegister(`DIF_REG_MODE, 32'h0);
    writeRegister(`DIF_REG_CONTROL, 32'h0);
    finishTest();
  endtask

  task automatic testAcquisitionMode();
    startTest("acquisition mode");
    writeRegister(`DIF_REG_MODE, 32'h0);
    writeRegister(`DIF_REG_VTH01, vth01Word);
    writeRegister(`DIF_REG_VTH2, vth2Word);
    writeRegister(`DIF_REG_CTEST_LO, cTestLowWord);
    writeRegister(`DIF_REG_CTEST_HI, cTestHighWord);
    writeRegister(`DIF_REG_CONTROL, 32'h4);
    @(posedge Clk);
    MicrorocAcquisitionData <= acqWord;
    MicrorocAcquisitionDataEnable <= 1'b1;
    AdcData <= adcWord;
    AdcDataEnable <= 1'b0;
    fifoFullLevel <= 1'b1;
    repeat (3) @(posedge Clk);
    checkAcquisitionBehavior();
    finishTest();
  endtask

  task automatic testAdcAndUndefinedMode();
    startTest("ADC and undefined mode");
    writeRegister(`DIF_REG_MODE, 32'h2);
    writeRegister(`DIF_REG_CONTROL, 32'h8);
    AdcDataEnable <= 1'b1;
    repeat (2) @(posedge Clk);
    checkValue("stream data", adcWord, OutTestData);
    checkValue("stream enable", 1, OutTestDataEnable);
    checkValue("full to ADC", 1, ExternalFifoFullToAdc);
    checkValue("full to acquisition", 0, ExternalFifoFullToMicrorocAcquisition);
    checkValue("start/stop from ADC run", 1, OutUsbStartStop);
    // Acquisition run alone must not start the ADC path
    writeRegister(`DIF_REG_CONTROL, 32'h4);
    repeat (2) @(posedge Clk);
    checkValue("start/stop with ADC run low", 0, OutUsbStartStop);
    writeRegister(`DIF_REG_MODE, 32'h7);
    repeat (2) @(posedge Clk);
    checkAcquisitionBehavior();
    fifoFullLevel <= 1'b0;
    MicrorocAcquisitionDataEnable <= 1'b0;
    AdcDataEnable <= 1'b0;
    writeRegister(`DIF_REG_CONTROL, 32'h0);
    writeRegister(`DIF_REG_MODE, 32'h0);
    finishTest();
  endtask

  task automatic runSweep(input string name, input bit toggleTrigger, input bit backPressure);
    logic [31:0] status;
    logic [15:0] expectedCount;
    scurveWord_u word;
    integer polls;
    integer step;
    bit idle;
    startTest(name);
    // Toggling every cycle gives one rising edge per two cycles
    expectedCount = toggleTrigger ? windowCycles / 2 : 16'd0;
    writeRegister(`DIF_REG_MODE, 32'h1);
    writeRegister(`DIF_REG_SCURVE_RANGE, {6'd0, sweepEndDac, 6'd0, sweepStartDac});
    writeRegister(`DIF_REG_SCURVE_WINDOW, {16'd0, windowCycles});
    @(posedge Clk);
    streamWords.delete();
    loadDacs.delete();
    razPulseCount <= 0;
    doneToAcquisitionCycles <= 0;
    triggerToggle <= toggleTrigger;
    fifoRandom <= backPressure;
    captureOn <= 1'b1;
    writeRegister(`DIF_REG_CONTROL, 32'h2);
    idle = 1'b0;
    for (polls = 0; polls < 400 && !idle; polls++) begin
      readRegister(`DIF_REG_STATUS, status);
      idle = !status[0];
    end
    assert (idle) else begin
      $display("timeout in test %s: sequencer still busy after %0d status reads",
               currentTest, polls);
      failCount++;
    end
    repeat (4) @(posedge Clk);
    captureOn <= 1'b0;
    triggerToggle <= 1'b0;
    fifoRandom <= 1'b0;
    checkValue("stream word count", 6, streamWords.size());
    checkValue("load pulse count", 3, loadDacs.size());
    // One RAZ per step, and Done stays with the sequencer
    checkValue("RAZ pulse count", 3, razPulseCount);
    checkValue("done to acquisition cycles", 0, doneToAcquisitionCycles);
    for (step = 0; step < 3; step++) begin
      if (streamWords.size() >= 2 * step + 2) begin
        word = streamWords[2 * step];
        checkValue("header marker", `DIF_SCURVE_MARKER, word.header.marker);
        checkValue("header DAC", sweepStartDac + step, word.header.dac);
        word = streamWords[2 * step + 1];
        checkValue("trigger count", expectedCount, word.count);
      end
      if (loadDacs.size() > step) begin
        checkValue("Vth0 at load", sweepStartDac + step, loadDacs[step]);
      end
    end
    readRegister(`DIF_REG_STATUS, status);
    checkValue("busy after sweep", 0, status[0]);
    writeRegister(`DIF_REG_MODE, 32'h0);
    finishTest();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    reset = 1'b1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatWrite = 32'd0;
    MicrorocAcquisitionData = '0;
    MicrorocAcquisitionDataEnable = 1'b0;
    AdcData = '0;
    AdcDataEnable = 1'b0;
    currentTest = "reset";
    repeat (16) @(posedge Clk);
    reset <= 1'b0;
    @(posedge Clk);

    testRegisters();
    testAcquisitionMode();
    testAdcAndUndefinedMode();
    runSweep("scurve sweep", 1'b1, 1'b0);
    runSweep("back-pressure", 1'b0, 1'b1);

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             testsRun, testsFailed, failCount);
    if (failCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+logic
logic/difModePkg.sv
logic/scurvePkg.sv
logic/commandRegisters.sv
logic/triggerWindowCounter.sv
logic/scurveSequencer.sv
logic/acquisitionSwitcher.sv
logic/difControlTop.sv
bench/difControlTb_assertions.sv
bench/difControlTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module difControlTb -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "^ALL TESTS PASSED$" sim.log \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }
